// File: mem_subsystem.f
hw/mem_pkg.sv
hw/mem_req_if.sv
hw/mem_control.sv
hw/inst_fetch.sv
hw/load_store_buffer.sv
hw/mem_subsystem.sv
testbench/tb_clock_gen.sv
testbench/mem_subsystem_props.sv
testbench/tb_mem_subsystem.sv

// File: Makefile
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= mem_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

  localparam int          NUM_OPS      = 300;
  localparam int          RESET_CYCLES = 10;
  localparam int          OP_CYCLES    = 40;
  localparam realtime     PERIOD       = 100.0;
  localparam int unsigned MEM_BYTES    = 1 << 18;

  logic              clk_in;
  logic              reset;
  logic              rdy_in;
  logic [7:0]        mem_din = 8'h00;
  logic [7:0]        mem_dout;
  logic [31:0]       mem_a;
  logic              mem_wr;
  logic              io_buffer_full;
  logic              redirect_valid;
  logic [31:0]       redirect_pc;
  logic              inst_valid;
  logic [31:0]       inst;
  logic [31:0]       inst_pc;
  logic              ls_valid;
  mem_pkg::ls_op_e   ls_op;
  logic [31:0]       ls_addr;
  logic [31:0]       ls_wdata;
  logic              ls_full;
  logic              load_valid;
  logic [31:0]       load_data;

  // bus-side memory and the reference copy used for predictions
  logic [7:0]  bus_mem [MEM_BYTES];
  logic [7:0]  ref_mem [MEM_BYTES];
  logic [31:0] load_q [$];
  logic [31:0] wr_addr_q [$];
  logic [7:0]  wr_byte_q [$];

  integer      seed;
  int          value_errors;
  int          other_errors;
  int          issued;
  int          inst_count;
  logic [31:0] expected_pc;

  tb_clock_gen #(.PERIOD(PERIOD)) u_tb_clock_gen (.clk(clk_in));

  mem_subsystem u_mem_subsystem (.*);

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      value_errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("%0t %s", $time, what);
  endtask

  function automatic logic [7:0] fill_byte(input int unsigned a);
    fill_byte = 8'(a ^ ((a >> 8) * 3) ^ ((a >> 16) * 29) ^ (a >> 5));
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] a);
    ref_word = {ref_mem[18'(a + 3)], ref_mem[18'(a + 2)], ref_mem[18'(a + 1)], ref_mem[18'(a)]};
  endfunction

  // pick one random load or store, predict its effect, drive it
  task automatic issue_op();
    mem_pkg::ls_op_e op;
    logic [31:0]     addr;
    logic [31:0]     wdata;
    logic [31:0]     raw;
    logic [31:0]     expected;
    int              n;
    op    = mem_pkg::ls_op_e'(3'($random(seed)));
    wdata = $random(seed);
    addr  = 32'h1_0000 + (32'($random(seed)) & 32'hff);
    n = (op == mem_pkg::op_lb || op == mem_pkg::op_lbu || op == mem_pkg::op_sb) ? 1 :
        (op == mem_pkg::op_lh || op == mem_pkg::op_lhu || op == mem_pkg::op_sh) ? 2 : 4;
    if (op >= mem_pkg::op_sb) begin
      if (($random(seed) & 7) == 0) begin
        addr = 32'h3_0000;
      end
      for (int i = 0; i < n; i++) begin
        ref_mem[18'(addr + i)] = wdata[8*i +: 8];
        wr_addr_q.push_back(addr + i);
        wr_byte_q.push_back(wdata[8*i +: 8]);
      end
    end else begin
      raw = ref_word(addr);
      case (op)
        mem_pkg::op_lb:  expected = {{24{raw[7]}}, raw[7:0]};
        mem_pkg::op_lh:  expected = {{16{raw[15]}}, raw[15:0]};
        mem_pkg::op_lbu: expected = {24'h0, raw[7:0]};
        mem_pkg::op_lhu: expected = {16'h0, raw[15:0]};
        default:         expected = raw;
      endcase
      load_q.push_back(expected);
    end
    ls_valid = 1'b1;
    ls_op    = op;
    ls_addr  = addr;
    ls_wdata = wdata;
    issued++;
  endtask

  task automatic drive_cycle();
    ls_valid       = 1'b0;
    redirect_valid = 1'b0;
    rdy_in         = ($random(seed) & 7) != 0;
    io_buffer_full = ($random(seed) & 3) == 0;
    if (rdy_in) begin
      if (($random(seed) & 31) == 0) begin
        redirect_valid = 1'b1;
        redirect_pc    = 32'($random(seed)) & 32'h0000_7ffc;
        expected_pc    = redirect_pc;
      end
      if (!ls_full && ($random(seed) & 1)) begin
        issue_op();
      end
    end
  endtask

  // byte memory, one cycle read latency
  always @(posedge clk_in) begin
    mem_din <= bus_mem[mem_a[17:0]];
    if (mem_wr) begin
      bus_mem[mem_a[17:0]] <= mem_dout;
    end
  end

  always @(posedge clk_in) begin
    if (!reset) begin
      if (!rdy_in && (inst_valid || load_valid || mem_wr)) begin
        report_failure("A strobe or a memory write happened while rdy_in was low.");
      end
      if (mem_wr && io_buffer_full && mem_a[17:16] == 2'b11) begin
        report_failure("An I/O write happened while io_buffer_full was high.");
      end
      if (inst_valid) begin
        check_value("inst_pc", expected_pc, inst_pc);
        check_value("inst", ref_word(expected_pc), inst);
        expected_pc = expected_pc + 4;
        inst_count++;
      end
      if (load_valid) begin
        if (load_q.size() == 0) begin
          report_failure("A load result arrived with no load outstanding.");
        end else begin
          check_value("load_data", load_q.pop_front(), load_data);
        end
      end
      if (mem_wr) begin
        if (wr_addr_q.size() == 0) begin
          report_failure("A memory write happened with no store outstanding.");
        end else begin
          check_value("mem_a", wr_addr_q.pop_front(), mem_a);
          check_value("mem_dout", 32'(wr_byte_q.pop_front()), 32'(mem_dout));
        end
      end
    end
  end

  initial begin
    #((NUM_OPS * OP_CYCLES + RESET_CYCLES) * PERIOD);
    $display("Timeout: the run did not finish in time, %0d operations issued.", issued);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    seed           = 32'h4599_730b;
    value_errors   = 0;
    other_errors   = 0;
    issued         = 0;
    inst_count     = 0;
    expected_pc    = '0;
    reset          = 1'b1;
    rdy_in         = 1'b1;
    io_buffer_full = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    ls_valid       = 1'b0;
    ls_op          = mem_pkg::op_lb;
    ls_addr        = '0;
    ls_wdata       = '0;
    for (int unsigned a = 0; a < MEM_BYTES; a++) begin
      bus_mem[a] = fill_byte(a);
      ref_mem[a] = fill_byte(a);
    end
    repeat (RESET_CYCLES) @(negedge clk_in);
    check_value("inst_valid", 32'h0, 32'(inst_valid));
    check_value("load_valid", 32'h0, 32'(load_valid));
    check_value("mem_wr", 32'h0, 32'(mem_wr));
    check_value("ls_full", 32'h0, 32'(ls_full));
    reset = 1'b0;
    while (issued < NUM_OPS) begin
      @(negedge clk_in);
      drive_cycle();
    end
    @(negedge clk_in);
    ls_valid       = 1'b0;
    redirect_valid = 1'b0;
    rdy_in         = 1'b1;
    io_buffer_full = 1'b0;
    // drain outstanding loads and stores
    while (load_q.size() != 0 || wr_addr_q.size() != 0) begin
      @(negedge clk_in);
    end
    repeat (10) @(negedge clk_in);
    if (inst_count == 0) begin
      report_failure("No instruction was fetched during the run.");
    end
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/mem_subsystem_props.sv
`timescale 1ns/1ps

module mem_subsystem_props (
  input logic                     clk_in,
  input logic                     reset,
  input logic                     rdy_in,
  input logic                     mem_wr,
  input logic [mem_pkg::XLEN-1:0] mem_a,
  input logic                     io_buffer_full,
  input logic                     fetch_done,
  input logic                     ls_done
);

  // no i/o byte goes out while the buffer is full
  assert property (@(posedge clk_in) disable iff (reset)
    mem_wr |-> !((mem_a[17:16] == 2'b11) && io_buffer_full))
    else $error("i/o write while io_buffer_full is high");

  // only one owner of the bus at a time
  assert property (@(posedge clk_in) disable iff (reset)
    !(fetch_done && ls_done))
    else $error("done on both buses in one cycle");

  assert property (@(posedge clk_in) disable iff (reset)
    !rdy_in |-> !mem_wr)
    else $error("mem_wr high while rdy_in is low");

endmodule

bind mem_control mem_subsystem_props u_mem_subsystem_props (
  .clk_in         (clk_in),
  .reset          (reset),
  .rdy_in         (rdy_in),
  .mem_wr         (mem_wr),
  .mem_a          (mem_a),
  .io_buffer_full (io_buffer_full),
  .fetch_done     (fetch_bus.done),
  .ls_done        (ls_bus.done)
);

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

// free-running clock for the testbench
module tb_clock_gen #(
  parameter realtime PERIOD = 100.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

endmodule

// File: hw/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
  input  logic                       clk_in,
  input  logic                       reset,
  // freeze everything while low
  input  logic                       rdy_in,

  // byte-wide memory bus
  input  logic [mem_pkg::BYTE_W-1:0] mem_din,
  output logic [mem_pkg::BYTE_W-1:0] mem_dout,
  output logic [mem_pkg::XLEN-1:0]   mem_a,
  output logic                       mem_wr,
  input  logic                       io_buffer_full,

  // fetch side
  input  logic                       redirect_valid,
  input  logic [mem_pkg::XLEN-1:0]   redirect_pc,
  output logic                       inst_valid,
  output logic [mem_pkg::XLEN-1:0]   inst,
  output logic [mem_pkg::XLEN-1:0]   inst_pc,

  // load/store side
  input  logic                       ls_valid,
  input  mem_pkg::ls_op_e            ls_op,
  input  logic [mem_pkg::XLEN-1:0]   ls_addr,
  input  logic [mem_pkg::XLEN-1:0]   ls_wdata,
  output logic                       ls_full,
  output logic                       load_valid,
  output logic [mem_pkg::XLEN-1:0]   load_data
);

  mem_req_if fetch_bus ();
  mem_req_if ls_bus ();

  mem_control u_mem_control (
    .clk_in         (clk_in),
    .reset          (reset),
    .rdy_in         (rdy_in),
    .mem_din        (mem_din),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr),
    .io_buffer_full (io_buffer_full),
    .fetch_bus      (fetch_bus.controller),
    .ls_bus         (ls_bus.controller)
  );

  inst_fetch u_inst_fetch (
    .clk_in         (clk_in),
    .reset          (reset),
    .rdy_in         (rdy_in),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .bus            (fetch_bus.requester),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .inst_pc        (inst_pc)
  );

  load_store_buffer u_load_store_buffer (
    .clk_in     (clk_in),
    .reset      (reset),
    .rdy_in     (rdy_in),
    .ls_valid   (ls_valid),
    .ls_op      (ls_op),
    .ls_addr    (ls_addr),
    .ls_wdata   (ls_wdata),
    .ls_full    (ls_full),
    .bus        (ls_bus.requester),
    .load_valid (load_valid),
    .load_data  (load_data)
  );

endmodule

// File: hw/load_store_buffer.sv
`timescale 1ns/1ps

module load_store_buffer (
  input  logic                     clk_in,
  input  logic                     reset,
  input  logic                     rdy_in,
  input  logic                     ls_valid,
  input  mem_pkg::ls_op_e          ls_op,
  input  logic [mem_pkg::XLEN-1:0] ls_addr,
  input  logic [mem_pkg::XLEN-1:0] ls_wdata,
  output logic                     ls_full,
  mem_req_if.requester             bus,
  output logic                     load_valid,
  output logic [mem_pkg::XLEN-1:0] load_data
);

  // queue storage
  mem_pkg::ls_op_e          op_q   [mem_pkg::LSB_DEPTH];
  logic [mem_pkg::XLEN-1:0] addr_q [mem_pkg::LSB_DEPTH];
  logic [mem_pkg::XLEN-1:0] data_q [mem_pkg::LSB_DEPTH];

  logic [mem_pkg::LSB_PTR_W-1:0] head;
  logic [mem_pkg::LSB_PTR_W-1:0] tail;
  logic [mem_pkg::LSB_CNT_W-1:0] count;
  mem_pkg::ls_op_e               head_op;
  logic                          push;
  logic                          pop;

  function automatic mem_pkg::mem_size_e op_size(input mem_pkg::ls_op_e op);
    case (op)
      mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sb: op_size = mem_pkg::size_byte;
      mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh: op_size = mem_pkg::size_half;
      default:                                         op_size = mem_pkg::size_word;
    endcase
  endfunction

  function automatic logic op_is_store(input mem_pkg::ls_op_e op);
    op_is_store = (op == mem_pkg::op_sb) || (op == mem_pkg::op_sh) || (op == mem_pkg::op_sw);
  endfunction

  // sign or zero fill above the loaded bytes
  function automatic logic [mem_pkg::XLEN-1:0] extend(
    input mem_pkg::ls_op_e          op,
    input logic [mem_pkg::XLEN-1:0] data
  );
    case (op)
      mem_pkg::op_lb:
        extend = {{(mem_pkg::XLEN-mem_pkg::BYTE_W){data[mem_pkg::BYTE_W-1]}},
                  data[mem_pkg::BYTE_W-1:0]};
      mem_pkg::op_lh:
        extend = {{(mem_pkg::XLEN-2*mem_pkg::BYTE_W){data[2*mem_pkg::BYTE_W-1]}},
                  data[2*mem_pkg::BYTE_W-1:0]};
      mem_pkg::op_lbu:
        extend = {{(mem_pkg::XLEN-mem_pkg::BYTE_W){1'b0}}, data[mem_pkg::BYTE_W-1:0]};
      mem_pkg::op_lhu:
        extend = {{(mem_pkg::XLEN-2*mem_pkg::BYTE_W){1'b0}}, data[2*mem_pkg::BYTE_W-1:0]};
      default:
        extend = data;
    endcase
  endfunction

  assign ls_full = (count == mem_pkg::LSB_FULL_CNT);
  // done is already quiet while paused
  assign push    = rdy_in && ls_valid && !ls_full;
  assign pop     = bus.done;
  assign head_op = op_q[head];

  // head entry drives the bus until its done
  assign bus.req   = (count != '0);
  assign bus.we    = op_is_store(head_op);
  assign bus.size  = op_size(head_op);
  assign bus.addr  = addr_q[head];
  assign bus.wdata = data_q[head];

  assign load_valid = bus.done && !op_is_store(head_op);
  assign load_data  = extend(head_op, bus.rdata);

  always_ff @(posedge clk_in) begin
    if (push) begin
      op_q[tail]   <= ls_op;
      addr_q[tail] <= ls_addr;
      data_q[tail] <= ls_wdata;
    end
  end

  always_ff @(posedge clk_in) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= tail + mem_pkg::LSB_PTR_ONE;
      end
      if (pop) begin
        head <= head + mem_pkg::LSB_PTR_ONE;
      end
      case ({push, pop})
        2'b10:   count <= count + mem_pkg::LSB_CNT_ONE;
        2'b01:   count <= count - mem_pkg::LSB_CNT_ONE;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hw/inst_fetch.sv
`timescale 1ns/1ps

module inst_fetch (
  input  logic                     clk_in,
  input  logic                     reset,
  input  logic                     rdy_in,
  input  logic                     redirect_valid,
  input  logic [mem_pkg::XLEN-1:0] redirect_pc,
  mem_req_if.requester             bus,
  output logic                     inst_valid,
  output logic [mem_pkg::XLEN-1:0] inst,
  output logic [mem_pkg::XLEN-1:0] inst_pc
);

  // pc is where the fetch stream continues, fetch_pc is the read on the bus
  logic [mem_pkg::XLEN-1:0] pc;
  logic [mem_pkg::XLEN-1:0] fetch_pc;
  // read in flight belongs to a path left by a redirect
  logic                     discard;

  // always wants the next word
  assign bus.req   = 1'b1;
  assign bus.we    = 1'b0;
  assign bus.size  = mem_pkg::size_word;
  assign bus.addr  = fetch_pc;
  assign bus.wdata = '0;

  // a redirect in the done cycle also kills that word
  assign inst_valid = bus.done && !discard && !redirect_valid;
  assign inst       = bus.rdata;
  assign inst_pc    = fetch_pc;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      pc       <= '0;
      fetch_pc <= '0;
      discard  <= 1'b0;
    end else if (rdy_in) begin
      if (redirect_valid) begin
        pc <= redirect_pc;
        if (bus.done) begin
          fetch_pc <= redirect_pc;
          discard  <= 1'b0;
        end else begin
          // fetch_pc must stay put until the old read finishes
          discard <= 1'b1;
        end
      end else if (bus.done) begin
        if (discard) begin
          fetch_pc <= pc;
          discard  <= 1'b0;
        end else begin
          fetch_pc <= fetch_pc + mem_pkg::INST_BYTES;
          pc       <= pc + mem_pkg::INST_BYTES;
        end
      end
    end
  end

endmodule

// File: hw/mem_control.sv
`timescale 1ns/1ps

module mem_control (
  input  logic                       clk_in,
  input  logic                       reset,
  input  logic                       rdy_in,
  input  logic [mem_pkg::BYTE_W-1:0] mem_din,
  output logic [mem_pkg::BYTE_W-1:0] mem_dout,
  output logic [mem_pkg::XLEN-1:0]   mem_a,
  output logic                       mem_wr,
  input  logic                       io_buffer_full,
  mem_req_if.controller              fetch_bus,
  mem_req_if.controller              ls_bus
);

  mem_pkg::mem_state_e       state;
  mem_pkg::grant_e           last_grant;
  mem_pkg::grant_e           pick;
  logic [mem_pkg::CNT_W-1:0] cnt;
  logic [mem_pkg::CNT_W-1:0] last_idx;
  logic [mem_pkg::CNT_W-1:0] cap_idx;
  logic [mem_pkg::CNT_W-1:0] addr_idx;
  logic                      done_q;
  logic                      start;
  logic                      io_hold;
  logic                      write_last;
  logic                      done_any;

  // request picked by the arbiter
  logic                      sel_we;
  logic [mem_pkg::XLEN-1:0]  sel_addr;
  mem_pkg::mem_size_e        sel_size;
  logic [mem_pkg::XLEN-1:0]  sel_wdata;

  // access in progress
  logic [mem_pkg::XLEN-1:0]  addr_q;
  mem_pkg::mem_size_e        size_q;
  logic [mem_pkg::XLEN-1:0]  wdata_q;
  logic [mem_pkg::XLEN-1:0]  rdata_q;
  logic [mem_pkg::XLEN-1:0]  byte_addr;

  function automatic logic [mem_pkg::CNT_W-1:0] last_byte(input mem_pkg::mem_size_e size);
    case (size)
      mem_pkg::size_byte: last_byte = mem_pkg::CNT_W'(0);
      mem_pkg::size_half: last_byte = mem_pkg::CNT_W'(1);
      default:            last_byte = mem_pkg::CNT_W'(3);
    endcase
  endfunction

  // alternate when both wait, otherwise take whoever asks
  always_comb begin
    if (fetch_bus.req && ls_bus.req) begin
      pick = (last_grant == mem_pkg::grant_fetch) ? mem_pkg::grant_ls : mem_pkg::grant_fetch;
    end else if (ls_bus.req) begin
      pick = mem_pkg::grant_ls;
    end else begin
      pick = mem_pkg::grant_fetch;
    end
    if (pick == mem_pkg::grant_ls) begin
      sel_we    = ls_bus.we;
      sel_addr  = ls_bus.addr;
      sel_size  = ls_bus.size;
      sel_wdata = ls_bus.wdata;
    end else begin
      sel_we    = fetch_bus.we;
      sel_addr  = fetch_bus.addr;
      sel_size  = fetch_bus.size;
      sel_wdata = fetch_bus.wdata;
    end
  end

  // a read's requester still holds req during its done cycle
  assign start    = (state == mem_pkg::st_idle) && !done_q && (fetch_bus.req || ls_bus.req);
  assign last_idx = last_byte(size_q);
  // mem_din carries the byte addressed one cycle earlier
  assign cap_idx  = cnt - mem_pkg::CNT_ONE;
  // while paused, or in the tail, keep presenting the byte still to be captured
  assign addr_idx = (rdy_in && state != mem_pkg::st_read_tail) ? cnt : cap_idx;
  assign byte_addr = addr_q + {{(mem_pkg::XLEN - mem_pkg::CNT_W){1'b0}}, addr_idx};

  assign io_hold    = (addr_q[mem_pkg::IO_MSB:mem_pkg::IO_LSB] == mem_pkg::IO_SEL) &&
                      io_buffer_full;
  assign mem_wr     = rdy_in && (state == mem_pkg::st_write) && !io_hold;
  assign write_last = mem_wr && (cnt == last_idx);
  assign done_any   = (rdy_in && done_q) || write_last;

  assign mem_a    = (state != mem_pkg::st_idle) ? byte_addr : '0;
  assign mem_dout = (state == mem_pkg::st_write) ?
                    wdata_q[cnt*mem_pkg::BYTE_W +: mem_pkg::BYTE_W] : '0;

  // last_grant names the current owner once an access has started
  assign fetch_bus.done  = done_any && (last_grant == mem_pkg::grant_fetch);
  assign ls_bus.done     = done_any && (last_grant == mem_pkg::grant_ls);
  assign fetch_bus.rdata = rdata_q;
  assign ls_bus.rdata    = rdata_q;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      state      <= mem_pkg::st_idle;
      last_grant <= mem_pkg::grant_ls;
      cnt        <= '0;
      done_q     <= 1'b0;
    end else if (rdy_in) begin
      done_q <= 1'b0;
      case (state)
        mem_pkg::st_idle: begin
          if (start) begin
            last_grant <= pick;
            cnt        <= '0;
            state      <= sel_we ? mem_pkg::st_write : mem_pkg::st_read;
          end
        end
        mem_pkg::st_read: begin
          cnt <= cnt + mem_pkg::CNT_ONE;
          if (cnt == last_idx) begin
            state <= mem_pkg::st_read_tail;
          end
        end
        mem_pkg::st_read_tail: begin
          // last byte lands now, done next cycle
          done_q <= 1'b1;
          state  <= mem_pkg::st_idle;
        end
        default: begin
          if (!io_hold) begin
            cnt <= cnt + mem_pkg::CNT_ONE;
            if (cnt == last_idx) begin
              state <= mem_pkg::st_idle;
            end
          end
        end
      endcase
    end
  end

  // request payload and little-endian read assembly
  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (start) begin
        addr_q  <= sel_addr;
        size_q  <= sel_size;
        wdata_q <= sel_wdata;
        rdata_q <= '0;
      end else if ((state == mem_pkg::st_read && cnt != '0) ||
                   state == mem_pkg::st_read_tail) begin
        rdata_q[cap_idx*mem_pkg::BYTE_W +: mem_pkg::BYTE_W] <= mem_din;
      end
    end
  end

endmodule

// File: hw/mem_req_if.sv
`timescale 1ns/1ps

// one requester talking to the memory controller
interface mem_req_if;

  logic                     req;
  logic                     we;
  logic [mem_pkg::XLEN-1:0] addr;
  mem_pkg::mem_size_e       size;
  logic [mem_pkg::XLEN-1:0] wdata;

  // single-cycle strobe, rdata only meaningful here for reads
  logic                     done;
  logic [mem_pkg::XLEN-1:0] rdata;

  modport requester (
    output req, we, addr, size, wdata,
    input  done, rdata
  );

  modport controller (
    input  req, we, addr, size, wdata,
    output done, rdata
  );

endinterface

// File: hw/mem_pkg.sv
package mem_pkg;

  // data path and bus widths
  localparam int unsigned XLEN   = 32;
  localparam int unsigned BYTE_W = 8;

  // load/store queue sizing
  localparam int unsigned LSB_DEPTH = 4;
  localparam int unsigned LSB_PTR_W = $clog2(LSB_DEPTH);
  localparam int unsigned LSB_CNT_W = $clog2(LSB_DEPTH + 1);
  localparam logic [LSB_PTR_W-1:0] LSB_PTR_ONE  = LSB_PTR_W'(1);
  localparam logic [LSB_CNT_W-1:0] LSB_CNT_ONE  = LSB_CNT_W'(1);
  localparam logic [LSB_CNT_W-1:0] LSB_FULL_CNT = LSB_CNT_W'(LSB_DEPTH);

  // instruction fetch step
  localparam int unsigned INST_BYTES = 4;

  // byte counter of the bus sequencer, wide enough for one word
  localparam int unsigned CNT_W = $clog2(INST_BYTES);
  localparam logic [CNT_W-1:0] CNT_ONE = CNT_W'(1);

  // address bits 17:16 both set select the i/o range
  localparam int unsigned IO_MSB = 17;
  localparam int unsigned IO_LSB = 16;
  localparam logic [IO_MSB-IO_LSB:0] IO_SEL = 2'b11;

  typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

  typedef enum logic [2:0] {
    op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw
  } ls_op_e;

  typedef enum logic [1:0] {st_idle, st_read, st_read_tail, st_write} mem_state_e;

  typedef enum logic {grant_fetch, grant_ls} grant_e;

endpackage
